// File: src.f
+incdir+hw
+incdir+tests
hw/mips_pkg.sv
hw/mips_decode.sv
hw/mips_regfile.sv
hw/mips_alu.sv
hw/mips_control.sv
hw/mips_cpu_bus.sv
tests/mips_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the core and its testbench with Verilator, then run the simulation.
# A $fatal in the testbench gives a nonzero exit status, and the script fails with it.
set -e

cd "$(dirname "$0")"

verilator --binary -f src.f --top-module mips_tb -o mips_tb_sim

./obj_dir/mips_tb_sim

// File: tests/mips_tests.svh
// Directed test tasks for the MIPS core, included inside the testbench module

localparam logic [31:0] DATA_BASE = 32'h0000_0100;
localparam logic [31:0] OP_A      = 32'h8000_0005;   // Negative when signed
localparam logic [31:0] OP_B      = 32'h0000_0007;
localparam logic [31:0] SH_V      = 32'hF000_00F0;   // Sign bit set for SRA

// Two's complement order, sign bits first and then magnitude
function automatic logic [31:0] signed_less(input logic [31:0] a, input logic [31:0] b);
    if (a[31] != b[31]) begin
        return {31'b0, a[31]};   // Negative side is the smaller
    end
    return {31'b0, a < b};
endfunction

// One R-type op, run with no waits then random waits
task automatic alu_case(input int fn, input logic [31:0] a, input logic [31:0] b,
                        input int sh, input logic [31:0] exp, input string name);
    logic [31:0] v0_first;
    logic [31:0] snap [logic [31:0]];
    prog.delete();
    prog.push_back(i_instr(15, 0, 8, a[31:16]));              // lui  $t0
    prog.push_back(i_instr(13, 8, 8, a[15:0]));               // ori  $t0
    prog.push_back(i_instr(15, 0, 9, b[31:16]));              // lui  $t1
    prog.push_back(i_instr(13, 9, 9, b[15:0]));               // ori  $t1
    prog.push_back(r_instr(fn <= 3 ? 0 : 8, 9, 10, sh, fn));  // Shifts take rt only
    prog.push_back(i_instr(43, 0, 10, DATA_BASE[15:0]));      // sw   $t2
    prog.push_back(r_instr(10, 0, 2, 0, 33));                 // addu $v0,$t2,$zero
    prog.push_back(r_instr(0, 0, 0, 0, 8));                   // jr   $zero
    run_program(1'b1);
    check(register_v0, exp, {name, " result in v0"});
    check(word_at(DATA_BASE), exp, {name, " stored result"});
    v0_first = register_v0;
    snap     = mem;
    run_program(1'b0);
    check(register_v0, v0_first, {name, " v0 with wait states"});
    check(mem.num(), snap.num(), {name, " memory size with wait states"});
    foreach (snap[k]) begin
        check(word_at(k), snap[k], {name, " memory with wait states"});
    end
endtask

task automatic alu_reg_ops();
    alu_case(33, OP_A, OP_B, 0, OP_A + OP_B, "addu");
    alu_case(35, OP_A, OP_B, 0, OP_A - OP_B, "subu");
    alu_case(36, OP_A, OP_B, 0, OP_A & OP_B, "and");
    alu_case(37, OP_A, OP_B, 0, OP_A | OP_B, "or");
    alu_case(38, OP_A, OP_B, 0, OP_A ^ OP_B, "xor");
    alu_case(42, OP_A, OP_B, 0, signed_less(OP_A, OP_B), "slt");
    alu_case(43, OP_A, OP_B, 0, {31'b0, OP_A < OP_B}, "sltu");
    alu_case(0, 0, SH_V, 4, SH_V << 4, "sll");
    alu_case(2, 0, SH_V, 4, SH_V >> 4, "srl");
    alu_case(3, 0, SH_V, 4, {{4{SH_V[31]}}, SH_V[31:4]}, "sra");   // Sign copied into top bits
endtask

task automatic imm_ops();
    logic [31:0] t0;
    logic [31:0] t1;
    logic [31:0] exp [$];
    prog.delete();
    prog.push_back(i_instr(9, 0, 8, 16'hFFFB));      // addiu $8,$0,-5
    prog.push_back(i_instr(15, 0, 9, 16'h8765));     // lui
    prog.push_back(i_instr(13, 9, 9, 16'h4321));     // ori
    prog.push_back(i_instr(12, 9, 10, 16'hF0F0));    // andi
    prog.push_back(i_instr(14, 8, 11, 16'h8001));    // xori, zero extended
    prog.push_back(i_instr(13, 0, 12, 16'h9000));    // ori
    prog.push_back(i_instr(10, 8, 13, 16'hFFFC));    // slti -5 < -4
    prog.push_back(i_instr(11, 9, 14, 16'hFFFF));    // sltiu against all ones
    prog.push_back(i_instr(11, 8, 15, 16'h0005));    // sltiu
    prog.push_back(i_instr(9, 0, 0, 16'h0077));      // Write to $zero
    for (int r = 8; r <= 15; r++) begin
        prog.push_back(i_instr(43, 0, r, 16'(DATA_BASE + 4 * (r - 8))));
    end
    prog.push_back(i_instr(43, 0, 0, 16'(DATA_BASE + 32)));   // sw $zero
    prog.push_back(r_instr(11, 0, 2, 0, 33));
    prog.push_back(r_instr(0, 0, 0, 0, 8));
    run_program(1'b1);
    t0 = sext16(16'hFFFB);
    t1 = {16'h8765, 16'h0000} | {16'h0000, 16'h4321};
    exp.push_back(t0);
    exp.push_back(t1);
    exp.push_back(t1 & {16'h0000, 16'hF0F0});
    exp.push_back(t0 ^ {16'h0000, 16'h8001});
    exp.push_back({16'h0000, 16'h9000});
    exp.push_back(signed_less(t0, sext16(16'hFFFC)));
    exp.push_back({31'b0, t1 < sext16(16'hFFFF)});
    exp.push_back({31'b0, t0 < sext16(16'h0005)});
    exp.push_back(32'h0);                            // $zero still reads zero
    foreach (exp[i]) begin
        check(word_at(DATA_BASE + 4 * i), exp[i], "immediate op result");
    end
    check(register_v0, exp[3], "xori result in v0");
endtask

task automatic store_load();
    logic [31:0] data;
    data = {16'h1234, 16'h5678};
    prog.delete();
    prog.push_back(i_instr(15, 0, 8, 16'h1234));
    prog.push_back(i_instr(13, 8, 8, 16'h5678));
    prog.push_back(i_instr(13, 0, 9, 16'h0200));     // Base $9
    prog.push_back(i_instr(43, 9, 8, 16'h0008));     // sw  $8,8($9)
    prog.push_back(i_instr(35, 9, 10, 16'h0008));    // lw  $10,8($9)
    prog.push_back(i_instr(9, 8, 11, 16'h0001));
    prog.push_back(i_instr(43, 9, 11, 16'hFFFC));    // Negative offset
    prog.push_back(i_instr(35, 9, 12, 16'hFFFC));
    prog.push_back(r_instr(10, 12, 2, 0, 33));       // $v0 = both loads
    prog.push_back(r_instr(0, 0, 0, 0, 8));
    run_program(1'b0);
    check(word_at(32'h200 + 32'd8), data, "stored word at base plus 8");
    check(word_at(32'h200 + sext16(16'hFFFC)), data + 32'd1, "stored word at base minus 4");
    check(register_v0, data + data + 32'd1, "loaded words in v0");
endtask

// Each skipped instruction would wreck $v0
task automatic control_flow();
    prog.delete();
    prog.push_back(i_instr(13, 0, 2, 16'h0001));     // v0 = 1
    prog.push_back(i_instr(13, 0, 8, 16'h0005));
    prog.push_back(i_instr(13, 0, 9, 16'h0005));
    prog.push_back(i_instr(4, 8, 9, 16'h0001));      // beq taken
    prog.push_back(i_instr(13, 0, 2, 16'h0BAD));
    prog.push_back(i_instr(9, 2, 2, 16'h0002));
    prog.push_back(i_instr(5, 8, 9, 16'h0001));      // bne falls through
    prog.push_back(i_instr(9, 2, 2, 16'h0004));
    prog.push_back(j_instr(`MIPS_RESET_VECTOR + 32'd40));
    prog.push_back(i_instr(13, 0, 2, 16'h0BAD));
    prog.push_back(i_instr(9, 2, 2, 16'h0008));      // Jump lands here
    prog.push_back(r_instr(0, 0, 0, 0, 8));
    run_program(1'b1);
    check(register_v0, 32'd1 + 32'd2 + 32'd4 + 32'd8, "branch and jump path");
endtask

task automatic halt_idle();
    prog.delete();
    prog.push_back(i_instr(13, 0, 2, 16'h0055));
    prog.push_back(r_instr(0, 0, 0, 0, 8));
    load_program();
    no_wait = 1'b1;
    pulse_reset();
    check({31'b0, active}, 32'd1, "active after reset");
    check({31'b0, read}, 32'd1, "first read after reset");
    check(address, `MIPS_RESET_VECTOR, "first fetch address");
    wait_halt();
    check(register_v0, 32'h55, "v0 before halt");
    repeat (20) begin
        @(posedge clk);
        #1;
        check({30'b0, read, write}, 32'd0, "bus idle while halted");
        check({31'b0, active}, 32'd0, "active while halted");
    end
endtask

// File: tests/mips_tb.sv
// Testbench top for the MIPS core: clock, reset, Avalon memory with wait states, runs directed tests
`timescale 1ns/1ns
`include "mips_params.svh"

module mips_tb;

    localparam int          CLK_HALF    = 20;          // 40 ns period
    localparam int          CYCLE_LIMIT = 4000;        // Worst case ~1500 with 3 waits per transfer
    localparam logic [15:0] LFSR_SEED   = 16'd35452;

    logic        clk;
    logic        reset;
    logic        active;
    logic [31:0] register_v0;
    logic [31:0] address;
    logic        write;
    logic        read;
    logic        waitrequest;
    logic [31:0] writedata;
    logic [3:0]  byteenable;
    logic [31:0] readdata;

    logic [31:0] mem [logic [31:0]];   // Keyed by byte address of each word
    logic [31:0] prog [$];             // Program for the next run
    bit          no_wait = 1'b1;       // Forces zero wait states
    int          cycles  = 0;

    mips_cpu_bus u_mips_cpu_bus (
        .clk         (clk),
        .reset       (reset),
        .active      (active),
        .register_v0 (register_v0),
        .address     (address),
        .write       (write),
        .read        (read),
        .waitrequest (waitrequest),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .readdata    (readdata)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // Galois LFSR, taps 16,14,13,11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [31:0] sext16(input logic [15:0] x);
        return {{16{x[15]}}, x};
    endfunction

    // Unwritten words read back a pattern built from the address
    function automatic logic [31:0] word_at(input logic [31:0] addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return {addr[15:0], addr[31:16]} ^ 32'h5A5A_5A5A;
    endfunction

    function automatic logic [31:0] r_instr(input int rs, input int rt, input int rd,
                                            input int sh, input int fn);
        return {6'd0, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn[5:0]};
    endfunction

    function automatic logic [31:0] i_instr(input int op, input int rs, input int rt,
                                            input logic [15:0] imm);
        return {op[5:0], rs[4:0], rt[4:0], imm};
    endfunction

    function automatic logic [31:0] j_instr(input logic [31:0] addr);
        return {6'd2, addr[27:2]};   // Upper PC bits come from the core
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("sim failed");
            $fatal(1, "value mismatch in %s", what);
        end
    endtask

    // Avalon slave, responds 2 ns after each rising edge
    initial begin : bus_model
        logic [15:0] lfsr;
        int          wait_left;
        bit          busy;
        waitrequest = 1'b0;
        readdata    = '0;
        lfsr        = LFSR_SEED;
        wait_left   = 0;
        busy        = 1'b0;
        forever begin
            @(posedge clk);
            #2;
            if (read === 1'b1 || write === 1'b1) begin
                if (!busy) begin   // New transfer, draw 0..3 waits
                    busy      = 1'b1;
                    wait_left = 0;
                    for (int i = 0; i < 2; i++) begin
                        lfsr      = lfsr_step(lfsr);
                        wait_left = wait_left * 2 + lfsr[0];
                    end
                    if (no_wait) wait_left = 0;
                end
                if (wait_left > 0) begin
                    waitrequest = 1'b1;
                    wait_left--;
                end else begin
                    waitrequest = 1'b0;   // Completes at the next edge
                    busy        = 1'b0;
                    if (read === 1'b1) begin
                        readdata = word_at(address);
                    end else begin
                        check({28'b0, byteenable}, 32'hF, "byteenable on store");
                        mem[address] = writedata;
                    end
                end
            end else begin
                waitrequest = 1'b0;
            end
        end
    end

    // Run limit over the whole simulation
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout: core did not finish within %0d cycles", CYCLE_LIMIT);
            $display("sim failed");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic load_program();
        mem.delete();
        foreach (prog[i]) begin
            mem[`MIPS_RESET_VECTOR + 4 * i] = prog[i];
        end
    endtask

    // Ends 2 ns after the edge that leaves reset
    task automatic pulse_reset();
        @(posedge clk);
        #2 reset = 1'b1;
        repeat (5) @(posedge clk);
        #2 reset = 1'b0;
    endtask

    task automatic wait_halt();
        do begin
            @(posedge clk);
            #1;
        end while (active !== 1'b0);
    endtask

    task automatic run_program(input bit zero_wait);
        load_program();
        no_wait = zero_wait;
        pulse_reset();
        wait_halt();
    endtask

    `include "mips_tests.svh"

    initial begin
        reset = 1'b1;
        alu_reg_ops();
        imm_ops();
        store_load();
        control_flow();
        halt_idle();
        $display("sim passed");
        $finish;
    end

endmodule

// File: hw/mips_cpu_bus.sv
// Top level of the core with Avalon-MM master pins, wiring decoder, register file, ALU and FSM
`timescale 1ns/1ns
`include "mips_params.svh"

module mips_cpu_bus (
    input  logic                      clk,
    input  logic                      reset,
    output logic                      active,
    output logic [`MIPS_XLEN-1:0]     register_v0,
    output logic [`MIPS_XLEN-1:0]     address,
    output logic                      write,
    output logic                      read,
    input  logic                      waitrequest,
    output logic [`MIPS_XLEN-1:0]     writedata,
    output logic [`MIPS_XLEN/8-1:0]   byteenable,
    input  logic [`MIPS_XLEN-1:0]     readdata
);
    import mips_pkg::*;

    decoded_t                    dec;
    bus_req_t                    bus;
    logic [`MIPS_XLEN-1:0]       instr;
    logic [`MIPS_XLEN-1:0]       rs_data;
    logic [`MIPS_XLEN-1:0]       rt_data;
    logic [`MIPS_XLEN-1:0]       alu_a;
    logic [`MIPS_XLEN-1:0]       alu_b;
    logic [`MIPS_XLEN-1:0]       alu_result;
    logic                        alu_zero;
    logic                        alu_b_sel_imm;
    logic                        rf_wr_en;
    logic [`MIPS_REG_ADDR_W-1:0] rf_wr_addr;
    logic [`MIPS_XLEN-1:0]       rf_wr_data;

    mips_decode u_mips_decode (
        .instr (instr),
        .dec   (dec)
    );

    mips_regfile u_mips_regfile (
        .clk     (clk),
        .reset   (reset),
        .rs_addr (dec.rs),
        .rt_addr (dec.rt),
        .wr_addr (rf_wr_addr),
        .wr_en   (rf_wr_en),
        .wr_data (rf_wr_data),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .v0      (register_v0)
    );

    // Shifts operate on rt, everything else on rs
    assign alu_a = dec.shift ? rt_data : rs_data;
    assign alu_b = alu_b_sel_imm ? dec.imm : rt_data;

    mips_alu u_mips_alu (
        .op     (dec.alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .shamt  (dec.shamt),
        .result (alu_result),
        .zero   (alu_zero)
    );

    mips_control u_mips_control (
        .clk           (clk),
        .reset         (reset),
        .waitrequest   (waitrequest),
        .readdata      (readdata),
        .dec           (dec),
        .rs_data       (rs_data),
        .rt_data       (rt_data),
        .alu_result    (alu_result),
        .alu_zero      (alu_zero),
        .instr         (instr),
        .alu_b_sel_imm (alu_b_sel_imm),
        .rf_wr_en      (rf_wr_en),
        .rf_wr_addr    (rf_wr_addr),
        .rf_wr_data    (rf_wr_data),
        .bus           (bus),
        .active        (active)
    );

    assign read       = bus.read;
    assign write      = bus.write;
    assign address    = bus.address;
    assign writedata  = bus.writedata;
    assign byteenable = {(`MIPS_XLEN/8){1'b1}};   // Word accesses only

endmodule

// File: hw/mips_control.sv
// FSM sequencing fetch, execute and memory phases, holding PC and IR and driving the Avalon request
`timescale 1ns/1ns
`include "mips_params.svh"

module mips_control (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        waitrequest,
    input  logic [`MIPS_XLEN-1:0]       readdata,
    input  mips_pkg::decoded_t          dec,
    input  logic [`MIPS_XLEN-1:0]       rs_data,
    input  logic [`MIPS_XLEN-1:0]       rt_data,
    input  logic [`MIPS_XLEN-1:0]       alu_result,
    input  logic                        alu_zero,
    output logic [`MIPS_XLEN-1:0]       instr,
    output logic                        alu_b_sel_imm,
    output logic                        rf_wr_en,
    output logic [`MIPS_REG_ADDR_W-1:0] rf_wr_addr,
    output logic [`MIPS_XLEN-1:0]       rf_wr_data,
    output mips_pkg::bus_req_t          bus,
    output logic                        active
);
    import mips_pkg::*;

    cpu_state_t            state;
    logic [`MIPS_XLEN-1:0] pc;
    logic [`MIPS_XLEN-1:0] pc_plus4;
    logic [`MIPS_XLEN-1:0] branch_target;
    logic [`MIPS_XLEN-1:0] jump_target;
    logic [`MIPS_XLEN-1:0] next_pc;
    logic                  taken;
    logic                  halt_pc;
    logic                  fetch_done;
    logic                  mem_op;

    assign halt_pc    = (pc == `MIPS_HALT_ADDR);
    assign fetch_done = (state == FETCH) && !halt_pc && !waitrequest;
    assign mem_op     = dec.load || dec.store;

    // Next PC, no delay slot
    assign pc_plus4      = pc + 'd4;
    assign branch_target = pc_plus4 + {dec.imm[`MIPS_XLEN-3:0], 2'b00};
    assign jump_target   = {pc_plus4[31:28], dec.target, 2'b00};   // Same 256 MB region
    assign taken         = (dec.beq && alu_zero) || (dec.bne && !alu_zero);

    always_comb begin
        if (dec.jr) begin
            next_pc = rs_data;
        end else if (dec.jump) begin
            next_pc = jump_target;
        end else if (taken) begin
            next_pc = branch_target;
        end else begin
            next_pc = pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH;
            pc    <= `MIPS_RESET_VECTOR;
        end else begin
            case (state)
                FETCH: begin
                    if (halt_pc) begin
                        state <= HALT;          // PC reached zero, no read issued
                    end else if (!waitrequest) begin
                        state <= EXEC;
                    end
                end
                EXEC: begin
                    if (mem_op) begin
                        state <= MEM;           // PC advances after the transfer
                    end else begin
                        state <= FETCH;
                        pc    <= next_pc;
                    end
                end
                MEM: begin
                    if (!waitrequest) begin
                        state <= FETCH;
                        pc    <= pc_plus4;
                    end
                end
                default: state <= HALT;         // Left only by reset
            endcase
        end
    end

    // IR captures the word on the completing fetch cycle
    always_ff @(posedge clk) begin
        if (fetch_done) begin
            instr <= readdata;
        end
    end

    assign alu_b_sel_imm = dec.use_imm;

    // Write-back, ALU result in EXEC or load data in MEM
    always_comb begin
        rf_wr_addr = dec.dest;
        if (state == MEM) begin
            rf_wr_en   = dec.load && !waitrequest;
            rf_wr_data = readdata;
        end else begin
            rf_wr_en   = (state == EXEC) && dec.reg_write;
            rf_wr_data = alu_result;
        end
    end

    // Avalon request, held steady until waitrequest drops
    always_comb begin
        bus = '0;
        case (state)
            FETCH: begin
                bus.read    = !halt_pc;
                bus.address = pc;
            end
            MEM: begin
                bus.read      = dec.load;
                bus.write     = dec.store;
                bus.address   = alu_result;   // rs plus sign-extended offset
                bus.writedata = rt_data;
            end
            default: bus = '0;
        endcase
    end

    assign active = (state != HALT);

endmodule

// File: hw/mips_alu.sv
// Combinational ALU for add, subtract, logic, set-less-than, immediate shifts and LUI
`timescale 1ns/1ns
`include "mips_params.svh"

module mips_alu (
    input  mips_pkg::alu_op_t     op,
    input  logic [`MIPS_XLEN-1:0] a,
    input  logic [`MIPS_XLEN-1:0] b,
    input  logic [4:0]            shamt,
    output logic [`MIPS_XLEN-1:0] result,
    output logic                  zero
);
    import mips_pkg::*;

    logic [`MIPS_XLEN-1:0] diff;
    logic                  lt_signed;
    logic                  lt_unsigned;

    assign diff        = a - b;
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;
    assign zero        = (diff == '0);   // Equality test for BEQ/BNE

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = diff;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_SLT:  result = {{(`MIPS_XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU: result = {{(`MIPS_XLEN-1){1'b0}}, lt_unsigned};
            ALU_SLL:  result = a << shamt;      // a carries rt here
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $unsigned($signed(a) >>> shamt);   // Keeps sign bit
            ALU_LUI:  result = {b[15:0], 16'h0000};
            default:  result = a + b;
        endcase
    end

endmodule

// File: hw/mips_regfile.sv
// General register file with two combinational reads, one write port and $zero tied low
`timescale 1ns/1ns
`include "mips_params.svh"

module mips_regfile (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [`MIPS_REG_ADDR_W-1:0] rs_addr,
    input  logic [`MIPS_REG_ADDR_W-1:0] rt_addr,
    input  logic [`MIPS_REG_ADDR_W-1:0] wr_addr,
    input  logic                        wr_en,
    input  logic [`MIPS_XLEN-1:0]       wr_data,
    output logic [`MIPS_XLEN-1:0]       rs_data,
    output logic [`MIPS_XLEN-1:0]       rt_data,
    output logic [`MIPS_XLEN-1:0]       v0
);

    // Entry 0 is not stored
    logic [`MIPS_XLEN-1:0] regs [1:`MIPS_REG_COUNT-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < `MIPS_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin   // Writes to $zero dropped
            regs[wr_addr] <= wr_data;
        end
    end

    assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];
    assign v0      = regs[`MIPS_V0_INDEX];

endmodule

// File: hw/mips_decode.sv
// Combinational decoder turning the instruction register into the decoded_t control bundle
`timescale 1ns/1ns
`include "mips_params.svh"

module mips_decode (
    input  logic [`MIPS_XLEN-1:0] instr,
    output mips_pkg::decoded_t    dec
);
    import mips_pkg::*;

    opcode_t               opcode;
    funct_t                funct;
    logic [`MIPS_XLEN-1:0] imm_sext;
    logic [`MIPS_XLEN-1:0] imm_zext;

    assign opcode   = opcode_t'(instr[31:26]);
    assign funct    = funct_t'(instr[5:0]);
    assign imm_sext = {{16{instr[15]}}, instr[15:0]};
    assign imm_zext = {16'h0000, instr[15:0]};

    always_comb begin
        dec        = '0;
        dec.rs     = instr[25:21];
        dec.rt     = instr[20:16];
        dec.dest   = instr[20:16];     // I-type writes rt
        dec.shamt  = instr[10:6];
        dec.target = instr[25:0];
        dec.imm    = imm_sext;
        dec.alu_op = ALU_ADD;
        case (opcode)
            OP_RTYPE: begin
                dec.dest      = instr[15:11];
                dec.reg_write = 1'b1;
                case (funct)
                    FN_ADDU: dec.alu_op = ALU_ADD;
                    FN_SUBU: dec.alu_op = ALU_SUB;
                    FN_AND:  dec.alu_op = ALU_AND;
                    FN_OR:   dec.alu_op = ALU_OR;
                    FN_XOR:  dec.alu_op = ALU_XOR;
                    FN_SLT:  dec.alu_op = ALU_SLT;
                    FN_SLTU: dec.alu_op = ALU_SLTU;
                    FN_SLL: begin
                        dec.alu_op = ALU_SLL;
                        dec.shift  = 1'b1;
                    end
                    FN_SRL: begin
                        dec.alu_op = ALU_SRL;
                        dec.shift  = 1'b1;
                    end
                    FN_SRA: begin
                        dec.alu_op = ALU_SRA;
                        dec.shift  = 1'b1;
                    end
                    FN_JR: begin
                        dec.reg_write = 1'b0;
                        dec.jr        = 1'b1;
                    end
                    default: dec.reg_write = 1'b0;   // Unsupported funct runs as a nop
                endcase
            end
            OP_J:   dec.jump = 1'b1;
            OP_BEQ: begin
                dec.alu_op = ALU_SUB;   // Compare rs and rt through the zero flag
                dec.beq    = 1'b1;
            end
            OP_BNE: begin
                dec.alu_op = ALU_SUB;
                dec.bne    = 1'b1;
            end
            OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                dec.use_imm   = 1'b1;
                dec.reg_write = 1'b1;
                case (opcode)
                    OP_SLTI:  dec.alu_op = ALU_SLT;
                    OP_SLTIU: dec.alu_op = ALU_SLTU;   // Sign extended, compared unsigned
                    OP_ANDI: begin
                        dec.alu_op = ALU_AND;
                        dec.imm    = imm_zext;
                    end
                    OP_ORI: begin
                        dec.alu_op = ALU_OR;
                        dec.imm    = imm_zext;
                    end
                    OP_XORI: begin
                        dec.alu_op = ALU_XOR;
                        dec.imm    = imm_zext;
                    end
                    OP_LUI: begin
                        dec.alu_op = ALU_LUI;
                        dec.imm    = imm_zext;
                    end
                    default: dec.alu_op = ALU_ADD;   // ADDIU
                endcase
            end
            OP_LW: begin
                dec.use_imm = 1'b1;   // Address is rs plus offset
                dec.load    = 1'b1;
            end
            OP_SW: begin
                dec.use_imm = 1'b1;
                dec.store   = 1'b1;
            end
            default: dec.reg_write = 1'b0;
        endcase
    end

endmodule

// File: hw/mips_pkg.sv
// Shared types for the core: opcode, function-code, ALU and state enums plus decode and bus structs
package mips_pkg;

    `include "mips_params.svh"

    // Primary opcodes, instr[31:26]
    typedef enum logic [5:0] {
        OP_RTYPE = 6'd0,
        OP_J     = 6'd2,
        OP_BEQ   = 6'd4,
        OP_BNE   = 6'd5,
        OP_ADDIU = 6'd9,
        OP_SLTI  = 6'd10,
        OP_SLTIU = 6'd11,
        OP_ANDI  = 6'd12,
        OP_ORI   = 6'd13,
        OP_XORI  = 6'd14,
        OP_LUI   = 6'd15,
        OP_LW    = 6'd35,
        OP_SW    = 6'd43
    } opcode_t;

    // R-type function codes, instr[5:0]
    typedef enum logic [5:0] {
        FN_SLL  = 6'd0,
        FN_SRL  = 6'd2,
        FN_SRA  = 6'd3,
        FN_JR   = 6'd8,
        FN_ADDU = 6'd33,
        FN_SUBU = 6'd35,
        FN_AND  = 6'd36,
        FN_OR   = 6'd37,
        FN_XOR  = 6'd38,
        FN_SLT  = 6'd42,
        FN_SLTU = 6'd43
    } funct_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_t;

    typedef enum logic [1:0] {
        FETCH = 2'd0,
        EXEC  = 2'd1,
        MEM   = 2'd2,
        HALT  = 2'd3
    } cpu_state_t;

    typedef struct packed {
        logic [`MIPS_REG_ADDR_W-1:0] rs;
        logic [`MIPS_REG_ADDR_W-1:0] rt;
        logic [`MIPS_REG_ADDR_W-1:0] dest;   // rd for R-type, rt for I-type
        logic [`MIPS_XLEN-1:0]       imm;    // Already sign or zero extended
        logic [4:0]                  shamt;
        alu_op_t                     alu_op;
        logic                        use_imm;
        logic                        shift;  // ALU a takes rt
        logic                        reg_write;
        logic                        load;
        logic                        store;
        logic                        beq;
        logic                        bne;
        logic                        jump;
        logic                        jr;
        logic [25:0]                 target; // J instr_index
    } decoded_t;

    // One Avalon master request
    typedef struct packed {
        logic                  read;
        logic                  write;
        logic [`MIPS_XLEN-1:0] address;
        logic [`MIPS_XLEN-1:0] writedata;
    } bus_req_t;

endpackage

// File: hw/mips_params.svh
// Core-wide widths and fixed addresses, included by the package and by every RTL module
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// Data and address width
`define MIPS_XLEN 32

// General register file
`define MIPS_REG_COUNT 32
`define MIPS_REG_ADDR_W 5

// First fetch after reset, the boot ROM region
`define MIPS_RESET_VECTOR 32'hBFC00000

// Fetching from here stops the core
`define MIPS_HALT_ADDR 32'h00000000

// Register shown on register_v0
`define MIPS_V0_INDEX 2

`endif
